// File: all.f
hdl/rv_pkg.sv
hdl/fetch_unit.sv
hdl/pipe_stage.sv
hdl/reg_file.sv
hdl/operand_bypass.sv
hdl/exec_unit.sv
hdl/rv_pipeline.sv
dv/rv_pipeline_tb.sv

// File: dv/rv_pipeline_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pipeline_tb;

  import rv_pkg::*;

  localparam int    IMEM_DEPTH   = 256;
  localparam int    IDX_W        = 8;
  localparam int    HALT_TIMEOUT = 200;
  localparam word_t RESET_PC     = 32'h0;

  // expected writeback slot where bubble marks a flushed wrong-path slot
  typedef struct packed {
    logic     bubble;
    word_t    pc;
    word_t    insn;
    logic     rd_we;
    reg_idx_t rd;
    word_t    rd_data;
  } expect_t;

  logic    clk;
  logic    rst = 1'b1;
  logic    rst_req;
  word_t   imem_addr;
  word_t   imem_data;
  logic    halt;
  commit_t commit;

  word_t   imem [0:IMEM_DEPTH-1];

  string   names[$];
  int      prog_base[$];
  int      exp_base[$];
  word_t   prog_all[$];
  expect_t exp_all[$];

  int      test_errors;
  int      passed;
  int      failed;

  rv_pipeline #(.RESET_PC(RESET_PC)) uut (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
    .halt(halt), .commit(commit)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reset request is changed at the falling edge and reaches the DUT on the rising edge
  always @(posedge clk) begin
    rst <= rst_req;
  end

  // same-cycle instruction memory that reads zero past the end of the program
  always_comb begin
    if (imem_addr < 32'(IMEM_DEPTH * 4)) begin
      imem_data = imem[imem_addr[IDX_W+1:2]];
    end else begin
      imem_data = '0;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  function automatic string strip_blanks(input string s);
    int first;
    int last;
    first = 0;
    last = s.len() - 1;
    while (first <= last && (s[first] == 8'h20 || s[first] == 8'h09)) begin
      first++;
    end
    while (last >= first && (s[last] == 8'h0a || s[last] == 8'h0d || s[last] == 8'h20)) begin
      last--;
    end
    if (last < first) begin
      return "";
    end
    return s.substr(first, last);
  endfunction

  task automatic read_stim();
    int      fd;
    int      code;
    int      rc;
    int      n;
    logic [7:0] tag;
    string   line;
    word_t   f0, f1, f2, f3, f4;
    expect_t rec;
    fd = $fopen("dv/rv_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file dv/rv_stim.txt");
      failed++;
      return;
    end
    code = $fscanf(fd, " %c", tag);
    while (code == 1) begin
      case (tag)
        "#": rc = $fgets(line, fd);
        "T": begin
          rc = $fgets(line, fd);
          names.push_back(strip_blanks(line));
          prog_base.push_back(prog_all.size());
          exp_base.push_back(exp_all.size());
        end
        "P": begin
          rc = $fscanf(fd, " %h", f0);
          prog_all.push_back(f0);
        end
        "E": begin
          rc = $fscanf(fd, " %h %h %h %h %h", f0, f1, f2, f3, f4);
          rec = '{bubble: 1'b0, pc: f0, insn: f1, rd_we: f2[0], rd: f3[4:0], rd_data: f4};
          exp_all.push_back(rec);
        end
        "B": begin
          rc = $fscanf(fd, " %d", n);
          rec = '0;
          rec.bubble = 1'b1;
          for (int i = 0; i < n; i++) begin
            exp_all.push_back(rec);
          end
        end
        default: begin
          $display("unknown record type in the stimulus file");
          failed++;
          rc = $fgets(line, fd);
        end
      endcase
      code = $fscanf(fd, " %c", tag);
    end
    $fclose(fd);
  endtask

  task automatic compare_commit(input expect_t rec);
    word_t exp_status;
    exp_status = rec.bubble ? 32'(CYCLE_TAKEN_BRANCH) : 32'(CYCLE_NO_STALL);
    check_value("commit.status", 32'(commit.status), exp_status);
    check_value("commit.pc", commit.pc, rec.pc);
    check_value("commit.insn", commit.insn, rec.insn);
    check_value("commit.rd_we", 32'(commit.rd_we), 32'(rec.rd_we));
    // destination fields only mean something when a register is written
    if (rec.rd_we) begin
      check_value("commit.rd", 32'(commit.rd), 32'(rec.rd));
      check_value("commit.rd_data", commit.rd_data, rec.rd_data);
    end
  endtask

  task automatic run_test(input int t);
    int   p_lo, p_hi, e_lo, e_hi;
    int   idx;
    int   cycles;
    logic done;
    p_lo = prog_base[t];
    p_hi = (t + 1 < names.size()) ? prog_base[t+1] : prog_all.size();
    e_lo = exp_base[t];
    e_hi = (t + 1 < names.size()) ? exp_base[t+1] : exp_all.size();
    test_errors = 0;
    rst_req = 1'b1;
    @(negedge clk);
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      imem[IDX_W'(i)] = (i < p_hi - p_lo) ? prog_all[p_lo+i] : '0;
    end
    for (int i = 1; i < 10; i++) begin
      @(negedge clk);
    end
    // outputs held while in reset
    check_value("imem_addr", imem_addr, RESET_PC);
    check_value("halt", 32'(halt), 32'h0);
    check_value("commit.rd_we", 32'(commit.rd_we), 32'h0);
    rst_req = 1'b0;
    idx = e_lo;
    cycles = 0;
    done = 1'b0;
    // everything but reset slots is matched in order
    while (!done && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (commit.status != CYCLE_RESET) begin
        if (idx < e_hi) begin
          compare_commit(exp_all[idx]);
          idx++;
        end else begin
          $display("unexpected commit from pc %h after the last expected one", commit.pc);
          test_errors++;
        end
      end
      if (halt) begin
        done = 1'b1;
      end
    end
    if (!done) begin
      $display("timeout: halt did not rise within %0d cycles", HALT_TIMEOUT);
      test_errors++;
    end else if (idx != e_hi) begin
      $display("%0d expected commits never appeared before halt", e_hi - idx);
      test_errors++;
    end
    if (test_errors == 0) begin
      passed++;
      $display("test %s: ok", names[t]);
    end else begin
      failed++;
      $display("test %s: %0d errors", names[t], test_errors);
    end
  endtask

  initial begin
    rst_req = 1'b1;
    passed = 0;
    failed = 0;
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      imem[IDX_W'(i)] = '0;
    end
    read_stim();
    for (int t = 0; t < names.size(); t++) begin
      run_test(t);
    end
    $display("%0d tests ok, %0d tests with errors", passed, failed);
    if (failed == 0 && passed > 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/rv_stim.txt
# T test name | P program word, from address 0 upward | B count of flushed slots
# E pc insn rd_we rd rd_data, all hex
T alu_ops
P 123450b7
P ffb00113
P 00112193
P 40115213
P 00815293
P 00409313
P 402083b3
P 00113433
P 0020c4b3
P 00000073
E 00000000 123450b7 1 01 12345000
E 00000004 ffb00113 1 02 fffffffb
E 00000008 00112193 1 03 00000001
E 0000000c 40115213 1 04 fffffffd
E 00000010 00815293 1 05 00ffffff
E 00000014 00409313 1 06 23450000
E 00000018 402083b3 1 07 12345005
E 0000001c 00113433 1 08 00000000
E 00000020 0020c4b3 1 09 edcbaffb
E 00000024 00000073 0 00 00000000
T forward_chain
P 00300093
P 00108133
P 0020a1b3
P 00116233
P 00508013
P 004002b3
P 00227333
P 00000073
E 00000000 00300093 1 01 00000003
E 00000004 00108133 1 02 00000006
E 00000008 0020a1b3 1 03 00000001
E 0000000c 00116233 1 04 00000007
E 00000010 00508013 1 00 00000008
E 00000014 004002b3 1 05 00000007
E 00000018 00227333 1 06 00000006
E 0000001c 00000073 0 00 00000000
T branch_jump
P 00100093
P 00008463
P 00009663
P 06300113
P 06200113
P 00c001ef
P 06100113
P 06000113
P 01118267
P 05f00113
P 003202b3
P 00000073
E 00000000 00100093 1 01 00000001
E 00000004 00008463 0 00 00000000
E 00000008 00009663 0 00 00000000
B 2
E 00000014 00c001ef 1 03 00000018
B 2
E 00000020 01118267 1 04 00000024
B 2
E 00000028 003202b3 1 05 0000003c
E 0000002c 00000073 0 00 00000000
T illegal_insn
P 02a00293
P 025282b3
P 00002283
P 00028333
P 00000073
E 00000000 02a00293 1 05 0000002a
E 00000000 00000000 0 00 00000000
E 00000000 00000000 0 00 00000000
E 0000000c 00028333 1 06 0000002a
E 00000010 00000073 0 00 00000000

// File: hdl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
  input  wire rv_pkg::execute_t x,
  input  wire rv_pkg::word_t    a,
  input  wire rv_pkg::word_t    b,
  output rv_pkg::word_t         result,
  output logic                  rd_we,
  output logic                  illegal,
  output logic                  redirect,
  output rv_pkg::word_t         redirect_pc
);

  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] shamt;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_j;
  word_t      link;
  logic       take;

  assign opcode = x.insn[6:0];
  assign funct3 = x.insn[14:12];
  assign funct7 = x.insn[31:25];
  assign shamt  = x.insn[24:20];

  // sign-extended immediates
  assign imm_i = {{20{x.insn[31]}}, x.insn[31:20]};
  assign imm_b = {{20{x.insn[31]}}, x.insn[7], x.insn[30:25], x.insn[11:8], 1'b0};
  assign imm_j = {{12{x.insn[31]}}, x.insn[19:12], x.insn[20], x.insn[30:21], 1'b0};

  assign link = x.pc + XLEN'(4);

  // branch condition over the six defined funct3 encodings
  always_comb begin
    case (funct3)
      3'b000:  take = (a == b);
      3'b001:  take = (a != b);
      3'b100:  take = ($signed(a) < $signed(b));
      3'b101:  take = ($signed(a) >= $signed(b));
      3'b110:  take = (a < b);
      3'b111:  take = (a >= b);
      default: take = 1'b0;
    endcase
  end

  always_comb begin
    result      = '0;
    rd_we       = 1'b0;
    illegal     = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    case (opcode)
      OP_LUI: begin
        result = {x.insn[31:12], 12'd0};
        rd_we  = 1'b1;
      end
      OP_REG_IMM: begin
        rd_we = 1'b1;
        case (funct3)
          3'b000: result = a + imm_i;
          3'b010: result = {31'd0, $signed(a) < $signed(imm_i)};
          3'b011: result = {31'd0, a < imm_i};
          3'b100: result = a ^ imm_i;
          3'b110: result = a | imm_i;
          3'b111: result = a & imm_i;
          3'b001: begin
            result  = a << shamt;
            illegal = (funct7 != 7'b0000000);
          end
          default: begin
            // srai when bit 30 is set, srli otherwise
            if (funct7 == 7'b0100000) begin
              result = $signed(a) >>> shamt;
            end else begin
              result = a >> shamt;
            end
            illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        endcase
      end
      OP_REG_REG: begin
        rd_we = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: result = a + b;
          10'b0100000_000: result = a - b;
          10'b0000000_001: result = a << b[4:0];
          10'b0000000_010: result = {31'd0, $signed(a) < $signed(b)};
          10'b0000000_011: result = {31'd0, a < b};
          10'b0000000_100: result = a ^ b;
          10'b0000000_101: result = a >> b[4:0];
          10'b0100000_101: result = $signed(a) >>> b[4:0];
          10'b0000000_110: result = a | b;
          10'b0000000_111: result = a & b;
          // M extension and anything else
          default:         illegal = 1'b1;
        endcase
      end
      OP_BRANCH: begin
        illegal     = (funct3 == 3'b010) || (funct3 == 3'b011);
        redirect    = take;
        redirect_pc = x.pc + imm_b;
      end
      OP_JAL: begin
        result      = link;
        rd_we       = 1'b1;
        redirect    = 1'b1;
        redirect_pc = x.pc + imm_j;
      end
      OP_JALR: begin
        result      = link;
        rd_we       = 1'b1;
        illegal     = (funct3 != 3'b000);
        redirect    = (funct3 == 3'b000);
        redirect_pc = (a + imm_i) & ~XLEN'(1);
      end
      OP_ENVIRON: begin
        // only ecall is supported
        illegal = (x.insn[31:7] != 25'd0);
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
    if (illegal) begin
      rd_we = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire logic          redirect,
  input  wire rv_pkg::word_t redirect_pc,
  output rv_pkg::word_t      pc
);

  import rv_pkg::*;

  word_t pc_next;

  // a resolved branch or jump in execute takes priority over the sequential path
  always_comb begin
    if (redirect) begin
      pc_next = redirect_pc;
    end else begin
      pc_next = pc + XLEN'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// File: hdl/operand_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module operand_bypass (
  input  wire rv_pkg::reg_idx_t src,
  input  wire rv_pkg::word_t    base,
  input  wire rv_pkg::memory_t  near_stage,
  input  wire rv_pkg::memory_t  far_stage,
  output rv_pkg::word_t         value
);

  import rv_pkg::*;

  reg_idx_t near_rd;
  reg_idx_t far_rd;
  logic     near_hit;
  logic     far_hit;

  assign near_rd = near_stage.insn[11:7];
  assign far_rd  = far_stage.insn[11:7];

  // only a stage that really writes a nonzero register can forward
  assign near_hit = near_stage.rd_we && (near_rd != 5'd0) && (near_rd == src);
  assign far_hit  = far_stage.rd_we && (far_rd != 5'd0) && (far_rd == src);

  // younger result wins
  always_comb begin
    if (near_hit) begin
      value = near_stage.result;
    end else if (far_hit) begin
      value = far_stage.result;
    end else begin
      value = base;
    end
  end

endmodule

`default_nettype wire

// File: hdl/pipe_stage.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
  parameter type payload_t = rv_pkg::decode_t
) (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     flush,
  input  wire payload_t d,
  output payload_t      q
);

  import rv_pkg::*;

  payload_t bubble;

  // empty slot, tagged with the reason it exists
  always_comb begin
    bubble = '0;
    if (rst) begin
      bubble.status = CYCLE_RESET;
    end else begin
      bubble.status = CYCLE_TAKEN_BRANCH;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      q <= bubble;
    end else begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire rv_pkg::reg_idx_t rs1,
  input  wire rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t         rs1_data,
  output rv_pkg::word_t         rs2_data,
  input  wire rv_pkg::reg_idx_t rd,
  input  wire rv_pkg::word_t    rd_data,
  input  wire logic             we
);

  import rv_pkg::*;

  // x0 has no storage
  word_t regs [1:31];

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rv_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pipeline #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  wire logic          clk,
  input  wire logic          rst,
  output rv_pkg::word_t      imem_addr,
  input  wire rv_pkg::word_t imem_data,
  output logic               halt,
  output rv_pkg::commit_t    commit
);

  import rv_pkg::*;

  word_t    f_pc;
  logic     redirect;
  word_t    redirect_pc;
  decode_t  d_in, d_q;
  execute_t x_in, x_q;
  memory_t  m_in, m_q, w_q;
  word_t    rf_rs1_data, rf_rs2_data;
  word_t    d_a, d_b, x_a, x_b;
  word_t    x_result;
  logic     x_rd_we, x_illegal;

  fetch_unit #(.RESET_PC(RESET_PC)) fetch_unit (
    .clk(clk), .rst(rst), .redirect(redirect), .redirect_pc(redirect_pc), .pc(f_pc)
  );

  assign imem_addr = f_pc;

  // fetch
  assign d_in.pc     = f_pc;
  assign d_in.insn   = imem_data;
  assign d_in.status = CYCLE_NO_STALL;

  pipe_stage #(.payload_t(decode_t)) d_stage (
    .clk(clk), .rst(rst), .flush(redirect), .d(d_in), .q(d_q)
  );

  // decode, with writeback forwarded around the register file
  reg_file rf (
    .clk(clk), .rst(rst), .rs1(d_q.insn[19:15]), .rs2(d_q.insn[24:20]),
    .rs1_data(rf_rs1_data), .rs2_data(rf_rs2_data),
    .rd(w_q.insn[11:7]), .rd_data(w_q.result), .we(w_q.rd_we)
  );

  operand_bypass d_byp_rs1 (
    .src(d_q.insn[19:15]), .base(rf_rs1_data), .near_stage(w_q), .far_stage(w_q), .value(d_a)
  );
  operand_bypass d_byp_rs2 (
    .src(d_q.insn[24:20]), .base(rf_rs2_data), .near_stage(w_q), .far_stage(w_q), .value(d_b)
  );

  assign x_in = '{pc: d_q.pc, insn: d_q.insn, a: d_a, b: d_b, status: d_q.status};

  pipe_stage #(.payload_t(execute_t)) x_stage (
    .clk(clk), .rst(rst), .flush(redirect), .d(x_in), .q(x_q)
  );

  // execute
  operand_bypass x_byp_rs1 (
    .src(x_q.insn[19:15]), .base(x_q.a), .near_stage(m_q), .far_stage(w_q), .value(x_a)
  );
  operand_bypass x_byp_rs2 (
    .src(x_q.insn[24:20]), .base(x_q.b), .near_stage(m_q), .far_stage(w_q), .value(x_b)
  );

  exec_unit exec_unit (
    .x(x_q), .a(x_a), .b(x_b), .result(x_result), .rd_we(x_rd_we), .illegal(x_illegal),
    .redirect(redirect), .redirect_pc(redirect_pc)
  );

  assign m_in = '{pc: x_q.pc, insn: x_q.insn, result: x_result, rd_we: x_rd_we,
                  illegal: x_illegal, status: x_q.status};

  // nothing past execute is ever squashed
  pipe_stage #(.payload_t(memory_t)) m_stage (
    .clk(clk), .rst(rst), .flush(1'b0), .d(m_in), .q(m_q)
  );
  pipe_stage #(.payload_t(memory_t)) w_stage (
    .clk(clk), .rst(rst), .flush(1'b0), .d(m_q), .q(w_q)
  );

  // writeback trace
  assign commit.pc      = w_q.illegal ? '0 : w_q.pc;
  assign commit.insn    = w_q.illegal ? '0 : w_q.insn;
  assign commit.status  = w_q.status;
  assign commit.rd_we   = w_q.rd_we;
  assign commit.rd      = w_q.insn[11:7];
  assign commit.rd_data = w_q.result;

  assign halt = (w_q.insn[6:0] == OP_ENVIRON);

endmodule

`default_nettype wire

// File: hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // register and address width
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // major opcodes, RV32I base encoding
  localparam logic [6:0] OP_LUI     = 7'b01_101_11;
  localparam logic [6:0] OP_REG_IMM = 7'b00_100_11;
  localparam logic [6:0] OP_REG_REG = 7'b01_100_11;
  localparam logic [6:0] OP_BRANCH  = 7'b11_000_11;
  localparam logic [6:0] OP_JAL     = 7'b11_011_11;
  localparam logic [6:0] OP_JALR    = 7'b11_001_11;
  localparam logic [6:0] OP_ENVIRON = 7'b11_100_11;

  // what occupies writeback in a given cycle
  typedef enum logic [2:0] {
    CYCLE_INVALID      = 3'd0,
    CYCLE_RESET        = 3'd1,
    CYCLE_NO_STALL     = 3'd2,
    CYCLE_TAKEN_BRANCH = 3'd4
  } cycle_status_e;

  // entering decode
  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
  } decode_t;

  // entering execute, a and b are the register operands read in decode
  typedef struct packed {
    word_t         pc;
    word_t         insn;
    word_t         a;
    word_t         b;
    cycle_status_e status;
  } execute_t;

  // memory and writeback share one layout
  typedef struct packed {
    word_t         pc;
    word_t         insn;
    word_t         result;
    logic          rd_we;
    logic          illegal;
    cycle_status_e status;
  } memory_t;

  // writeback trace, pc and insn read zero for an illegal instruction
  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
    logic          rd_we;
    reg_idx_t      rd;
    word_t         rd_data;
  } commit_t;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the pipeline testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps --top-module rv_pipeline_tb \
  --Mdir obj_dir -o rv_pipeline_sim -f all.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/rv_pipeline_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "All tests passed" sim.log; then
  echo "run.sh: simulation reported success"
  exit 0
else
  echo "run.sh: simulation reported failure"
  exit 1
fi
